//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_can_bridge -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_can_bridge)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- design/can_bridge_pkg.sv
`default_nettype none

`include "can_bridge_settings.svh"

package can_bridge_pkg;

  // Identifier register layout
  typedef struct packed {
    logic [`CAN_ID_W-1:0]             id;    // Left aligned in the word
    logic [`CAN_WORD_W-`CAN_ID_W-1:0] zero;  // Unused and written as zero
  } can_id_word_s;

  // Data register layout with two message bytes per word
  typedef struct packed {
    logic [7:0] hi;  // Upper byte of the register
    logic [7:0] lo;  // Lower byte of the register
  } can_byte_pair_s;

  // One node register word. The address decides which view applies.
  // Identifier registers use id_word and data registers use pair
  typedef union packed {
    can_id_word_s   id_word;
    can_byte_pair_s pair;
  } can_reg_word_u;

endpackage

`default_nettype wire

//--- design/can_bridge_settings.svh
`ifndef CAN_BRIDGE_SETTINGS_SVH
`define CAN_BRIDGE_SETTINGS_SVH

`define CAN_ADDR_W       5
`define CAN_WORD_W       16
`define CAN_MSG_W        76
`define CAN_SEL_W        5
`define CAN_ID_W         11
`define CAN_OP_W         2

`define OP_SEND          2'd0
`define OP_TRIM          2'd1
`define OP_BUS_RESET     2'd2
`define OP_COMPARE       2'd3

// Transmit registers
`define ADDR_TX_ID       5'h0C
`define ADDR_TX_D12      5'h0A
`define ADDR_TX_D34      5'h09
`define ADDR_TX_D56      5'h08
`define ADDR_TX_D78      5'h07

`define ADDR_GENERAL     5'h0E
`define ADDR_TX_CTRL     5'h0D
`define ADDR_IRQ         5'h12
`define ADDR_BIT_TIMING  5'h10
`define ADDR_ACCEPT      5'h11

// Receive registers
`define ADDR_RX_ID       5'h05
`define ADDR_RX_D12      5'h04
`define ADDR_RX_D34      5'h03
`define ADDR_RX_D56      5'h02
`define ADDR_RX_D78      5'h01

`define WORD_GENERAL     16'h009C
`define WORD_TX_CTRL     16'h8008
`define WORD_IRQ_CLEAR   16'h8070

// ID 0x555 and all data bytes 0xAA give the most bit transitions
`define TRIM_PATTERN     76'h555_AAAA_AAAA_AAAA_AAAA

`define INIT_BIT_TIMING  16'h2301
`define INIT_ACCEPT      16'h0000
`define INIT_IRQ         16'h8000

// Init table with entry 0 in the low bits and written first
`define INIT_LEN         4
`define INIT_ADDR_TABLE  {`ADDR_GENERAL, `ADDR_IRQ, `ADDR_ACCEPT, `ADDR_BIT_TIMING}
`define INIT_WORD_TABLE  {`WORD_GENERAL, `INIT_IRQ, `INIT_ACCEPT, `INIT_BIT_TIMING}

`endif

//--- design/can_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_bridge_settings.svh"

module can_bridge_top import can_bridge_pkg::*; (
  input  wire                      clock,
  input  wire                      rst,
  // Host requests
  input  wire                      req_valid,
  input  wire [`CAN_OP_W-1:0]      req_op,
  input  wire [`CAN_MSG_W-1:0]     req_msg,
  input  wire [2*`CAN_SEL_W-1:0]   req_sel,      // {rx select, tx select}
  output wire                      req_ready,
  // Node register bus
  output wire [`CAN_ADDR_W-1:0]    reg_addr,
  output wire [`CAN_WORD_W-1:0]    reg_wdata,
  output wire                      reg_wr,
  output wire                      reg_rd,
  input  wire [`CAN_WORD_W-1:0]    reg_rdata,
  input  wire                      rx_pending,
  // Received messages to the host
  output wire                      rx_valid,
  output wire [`CAN_MSG_W-1:0]     rx_msg,
  input  wire                      rx_ready,
  output wire [`CAN_SEL_W-1:0]     comp_tx_sel,
  output wire [`CAN_SEL_W-1:0]     comp_rx_sel
);

  logic                    cmd_write;
  logic                    cmd_trim;
  logic                    cmd_init;
  can_reg_word_u           init_word;
  logic [`CAN_MSG_W-1:0]   tx_msg;
  logic                    rd_capture;
  logic [2:0]              rd_index;
  logic                    rx_busy;

  can_reg_sequencer i_can_reg_sequencer (
    .clock       (clock),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_msg     (req_msg),
    .req_sel     (req_sel),
    .rx_pending  (rx_pending),
    .rx_busy     (rx_busy),
    .req_ready   (req_ready),
    .reg_addr    (reg_addr),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .cmd_write   (cmd_write),
    .cmd_trim    (cmd_trim),
    .cmd_init    (cmd_init),
    .init_word   (init_word),
    .tx_msg      (tx_msg),
    .rd_capture  (rd_capture),
    .rd_index    (rd_index),
    .comp_tx_sel (comp_tx_sel),
    .comp_rx_sel (comp_rx_sel)
  );

  can_interface i_can_interface (
    .cmd_write (cmd_write),
    .cmd_trim  (cmd_trim),
    .cmd_init  (cmd_init),
    .reg_addr  (reg_addr),
    .init_word (init_word),
    .tx_msg    (tx_msg),
    .reg_wdata (reg_wdata)
  );

  can_rx_assembler i_can_rx_assembler (
    .clock      (clock),
    .rst        (rst),
    .rd_capture (rd_capture),
    .rd_index   (rd_index),
    .reg_rdata  (reg_rdata),
    .rx_ready   (rx_ready),
    .rx_valid   (rx_valid),
    .rx_msg     (rx_msg),
    .rx_busy    (rx_busy)
  );

endmodule

`default_nettype wire

//--- design/can_interface.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_bridge_settings.svh"

module can_interface import can_bridge_pkg::*; (
  input  wire                      cmd_write,
  input  wire                      cmd_trim,
  input  wire                      cmd_init,
  input  wire [`CAN_ADDR_W-1:0]    reg_addr,
  input  wire can_reg_word_u       init_word,
  input  wire [`CAN_MSG_W-1:0]     tx_msg,
  output can_reg_word_u            reg_wdata
);

  logic [`CAN_MSG_W-1:0] src_msg;  // Message being written out

  // Byte k of the message sits at bits 8k+7:8k
  function automatic logic [7:0] msg_byte(input logic [`CAN_MSG_W-1:0] msg,
                                          input int unsigned           k);
    msg_byte = msg[8*k +: 8];
  endfunction

  function automatic can_reg_word_u pair_word(input logic [7:0] hi,
                                              input logic [7:0] lo);
    can_reg_word_u w;
    w.pair.hi = hi;
    w.pair.lo = lo;
    return w;
  endfunction

  function automatic can_reg_word_u id_word(input logic [`CAN_MSG_W-1:0] msg);
    can_reg_word_u w;
    w.id_word.id   = msg[`CAN_MSG_W-2 -: `CAN_ID_W];  // Bits 74:64 below reserved bit 75
    w.id_word.zero = '0;
    return w;
  endfunction

  assign src_msg = cmd_trim ? `TRIM_PATTERN : tx_msg;

  always_comb begin
    reg_wdata = '0;
    if (cmd_init) begin
      reg_wdata = init_word;  // Table word chosen by the sequencer
    end else if (cmd_write || cmd_trim) begin
      case (reg_addr)
        `ADDR_TX_ID: begin
          reg_wdata = id_word(src_msg);
        end
        `ADDR_TX_D12: begin
          reg_wdata = pair_word(msg_byte(src_msg, 7), msg_byte(src_msg, 5));
        end
        `ADDR_TX_D34: begin
          reg_wdata = pair_word(msg_byte(src_msg, 6), msg_byte(src_msg, 4));
        end
        // Lower data registers are byte swapped in the node
        `ADDR_TX_D56: begin
          reg_wdata = pair_word(msg_byte(src_msg, 0), msg_byte(src_msg, 1));
        end
        `ADDR_TX_D78: begin
          reg_wdata = pair_word(msg_byte(src_msg, 2), msg_byte(src_msg, 3));
        end
        `ADDR_GENERAL: begin
          reg_wdata = `WORD_GENERAL;
        end
        `ADDR_TX_CTRL: begin
          reg_wdata = `WORD_TX_CTRL;     // Transmit request
        end
        `ADDR_IRQ: begin
          reg_wdata = `WORD_IRQ_CLEAR;   // Bus reset and receive done
        end
        default: begin
          reg_wdata = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/can_reg_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_bridge_settings.svh"

module can_reg_sequencer import can_bridge_pkg::*; (
  input  wire                      clock,
  input  wire                      rst,
  input  wire                      req_valid,
  input  wire [`CAN_OP_W-1:0]      req_op,
  input  wire [`CAN_MSG_W-1:0]     req_msg,
  input  wire [2*`CAN_SEL_W-1:0]   req_sel,      // {rx select, tx select}
  input  wire                      rx_pending,
  input  wire                      rx_busy,
  output logic                     req_ready,
  output logic [`CAN_ADDR_W-1:0]   reg_addr,
  output logic                     reg_wr,
  output logic                     reg_rd,
  output logic                     cmd_write,
  output logic                     cmd_trim,
  output logic                     cmd_init,
  output can_reg_word_u            init_word,
  output logic [`CAN_MSG_W-1:0]    tx_msg,
  output logic                     rd_capture,   // reg_rdata valid this cycle
  output logic [2:0]               rd_index,     // 0 is RX_ID, 4 is RX_D78
  output logic [`CAN_SEL_W-1:0]    comp_tx_sel,
  output logic [`CAN_SEL_W-1:0]    comp_rx_sel
);

  localparam logic [2:0] ST_INIT = 3'd0;
  localparam logic [2:0] ST_IDLE = 3'd1;
  localparam logic [2:0] ST_TX   = 3'd2;
  localparam logic [2:0] ST_BRST = 3'd3;
  localparam logic [2:0] ST_RX   = 3'd4;

  localparam logic [2:0] TX_STEPS   = 3'd7;  // ID, four data words, GENERAL, TX_CTRL
  localparam logic [2:0] BRST_STEPS = 3'd2;
  localparam logic [2:0] RX_READS   = 3'd5;

  localparam logic [`INIT_LEN*`CAN_ADDR_W-1:0] INIT_ADDRS = `INIT_ADDR_TABLE;
  localparam logic [`INIT_LEN*`CAN_WORD_W-1:0] INIT_WORDS = `INIT_WORD_TABLE;

  logic [2:0]              state;
  logic [2:0]              state_d;
  logic [2:0]              idx;             // Step within the current state
  logic [2:0]              idx_d;
  logic                    trim_q;          // Current transmit uses the trim pattern
  logic                    rx_start;
  logic                    req_fire;
  logic [`CAN_ADDR_W-1:0]  addr_d;
  can_reg_word_u           init_word_d;
  logic                    wr_d;
  logic                    rd_d;
  logic                    write_d;
  logic                    trim_d;
  logic                    init_d;
  logic [2:0]              rd_sel;          // Index of the read now on the bus

  function automatic logic [`CAN_ADDR_W-1:0] tx_addr(input logic [2:0] i);
    case (i)
      3'd0:    tx_addr = `ADDR_TX_ID;
      3'd1:    tx_addr = `ADDR_TX_D12;
      3'd2:    tx_addr = `ADDR_TX_D34;
      3'd3:    tx_addr = `ADDR_TX_D56;
      3'd4:    tx_addr = `ADDR_TX_D78;
      3'd5:    tx_addr = `ADDR_GENERAL;
      default: tx_addr = `ADDR_TX_CTRL;
    endcase
  endfunction

  function automatic logic [`CAN_ADDR_W-1:0] rx_addr(input logic [2:0] i);
    case (i)
      3'd0:    rx_addr = `ADDR_RX_ID;
      3'd1:    rx_addr = `ADDR_RX_D12;
      3'd2:    rx_addr = `ADDR_RX_D34;
      3'd3:    rx_addr = `ADDR_RX_D56;
      3'd4:    rx_addr = `ADDR_RX_D78;
      default: rx_addr = `ADDR_IRQ;        // Clears rx_pending in the node
    endcase
  endfunction

  // A pending receive wins over a new host request
  assign rx_start  = rx_pending && !rx_busy;
  assign req_ready = (state == ST_IDLE) && !rx_start;
  assign req_fire  = req_valid && req_ready;

  always_comb begin
    state_d     = state;
    idx_d       = idx;
    addr_d      = '0;
    init_word_d = '0;
    wr_d        = 1'b0;
    rd_d        = 1'b0;
    write_d     = 1'b0;
    trim_d      = 1'b0;
    init_d      = 1'b0;
    case (state)
      ST_INIT: begin
        if (idx == `INIT_LEN) begin
          state_d = ST_IDLE;
          idx_d   = '0;
        end else begin
          wr_d        = 1'b1;
          init_d      = 1'b1;
          addr_d      = INIT_ADDRS[idx*`CAN_ADDR_W +: `CAN_ADDR_W];
          init_word_d = INIT_WORDS[idx*`CAN_WORD_W +: `CAN_WORD_W];
          idx_d       = idx + 3'd1;
        end
      end
      ST_IDLE: begin
        if (rx_start) begin
          rd_d    = 1'b1;
          addr_d  = rx_addr(idx);          // idx is zero in idle
          idx_d   = idx + 3'd1;
          state_d = ST_RX;
        end else if (req_fire) begin
          case (req_op)
            `OP_SEND, `OP_TRIM: begin
              wr_d    = 1'b1;
              write_d = 1'b1;
              trim_d  = (req_op == `OP_TRIM);
              addr_d  = tx_addr(idx);
              idx_d   = idx + 3'd1;
              state_d = ST_TX;
            end
            `OP_BUS_RESET: begin
              wr_d    = 1'b1;
              write_d = 1'b1;
              addr_d  = `ADDR_GENERAL;
              idx_d   = idx + 3'd1;
              state_d = ST_BRST;
            end
            default: ;                     // Compare only updates the selects
          endcase
        end
      end
      ST_TX: begin
        if (idx == TX_STEPS) begin
          state_d = ST_IDLE;
          idx_d   = '0;
        end else begin
          wr_d    = 1'b1;
          write_d = 1'b1;
          trim_d  = trim_q;
          addr_d  = tx_addr(idx);
          idx_d   = idx + 3'd1;
        end
      end
      ST_BRST: begin
        if (idx == BRST_STEPS) begin
          state_d = ST_IDLE;
          idx_d   = '0;
        end else begin
          wr_d    = 1'b1;
          write_d = 1'b1;
          addr_d  = `ADDR_IRQ;
          idx_d   = idx + 3'd1;
        end
      end
      ST_RX: begin
        if (idx < RX_READS) begin
          rd_d   = 1'b1;
          addr_d = rx_addr(idx);
          idx_d  = idx + 3'd1;
        end else if (idx == RX_READS) begin
          wr_d    = 1'b1;
          write_d = 1'b1;
          addr_d  = rx_addr(idx);
          idx_d   = idx + 3'd1;
        end else begin
          state_d = ST_IDLE;
          idx_d   = '0;
        end
      end
      default: begin
        state_d = ST_IDLE;
        idx_d   = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state       <= ST_INIT;
      idx         <= '0;
      trim_q      <= 1'b0;
      reg_wr      <= 1'b0;
      reg_rd      <= 1'b0;
      cmd_write   <= 1'b0;
      cmd_trim    <= 1'b0;
      cmd_init    <= 1'b0;
      rd_capture  <= 1'b0;
      comp_tx_sel <= '0;
      comp_rx_sel <= '0;
    end else begin
      state      <= state_d;
      idx        <= idx_d;
      reg_wr     <= wr_d;
      reg_rd     <= rd_d;
      cmd_write  <= write_d;
      cmd_trim   <= trim_d;
      cmd_init   <= init_d;
      rd_capture <= reg_rd;                // Node answers one cycle later
      if (req_fire && (req_op == `OP_SEND || req_op == `OP_TRIM)) begin
        trim_q <= (req_op == `OP_TRIM);
      end
      if (req_fire && req_op == `OP_COMPARE) begin
        comp_tx_sel <= req_sel[`CAN_SEL_W-1:0];
        comp_rx_sel <= req_sel[2*`CAN_SEL_W-1:`CAN_SEL_W];
      end
    end
  end

  always_ff @(posedge clock) begin
    reg_addr  <= addr_d;
    init_word <= init_word_d;
    rd_sel    <= idx;
    rd_index  <= rd_sel;
    if (req_fire && req_op == `OP_SEND) begin
      tx_msg <= req_msg;
    end
  end

endmodule

`default_nettype wire

//--- design/can_rx_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_bridge_settings.svh"

module can_rx_assembler import can_bridge_pkg::*; (
  input  wire                      clock,
  input  wire                      rst,
  input  wire                      rd_capture,
  input  wire [2:0]                rd_index,
  input  wire can_reg_word_u       reg_rdata,
  input  wire                      rx_ready,
  output logic                     rx_valid,
  output logic [`CAN_MSG_W-1:0]    rx_msg,
  output logic                     rx_busy
);

  localparam logic [2:0] IDX_ID  = 3'd0;
  localparam logic [2:0] IDX_D12 = 3'd1;
  localparam logic [2:0] IDX_D34 = 3'd2;
  localparam logic [2:0] IDX_D56 = 3'd3;
  localparam logic [2:0] IDX_D78 = 3'd4;  // Last word of a message

  logic [`CAN_ID_W-1:0] id_q;
  logic [63:0]          data_q;
  logic                 asm_active;       // Between first and last word

  always_ff @(posedge clock) begin
    if (rst) begin
      rx_valid   <= 1'b0;
      asm_active <= 1'b0;
    end else begin
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      if (rd_capture && rd_index == IDX_ID) begin
        asm_active <= 1'b1;
      end
      if (rd_capture && rd_index == IDX_D78) begin
        asm_active <= 1'b0;
        rx_valid   <= 1'b1;
      end
    end
  end

  // Same byte pairing as the transmit registers
  always_ff @(posedge clock) begin
    if (rd_capture) begin
      case (rd_index)
        IDX_ID: begin
          id_q <= reg_rdata.id_word.id;
        end
        IDX_D12: begin
          data_q[63:56] <= reg_rdata.pair.hi;
          data_q[47:40] <= reg_rdata.pair.lo;
        end
        IDX_D34: begin
          data_q[55:48] <= reg_rdata.pair.hi;
          data_q[39:32] <= reg_rdata.pair.lo;
        end
        IDX_D56: begin
          data_q[7:0]   <= reg_rdata.pair.hi;
          data_q[15:8]  <= reg_rdata.pair.lo;
        end
        IDX_D78: begin
          data_q[23:16] <= reg_rdata.pair.hi;
          data_q[31:24] <= reg_rdata.pair.lo;
        end
        default: ;
      endcase
    end
  end

  assign rx_msg  = {1'b0, id_q, data_q};  // Reserved bit 75 reads zero
  assign rx_busy = rx_valid || asm_active;

endmodule

`default_nettype wire

//--- list.f
+incdir+design
+incdir+test
design/can_bridge_pkg.sv
design/can_reg_sequencer.sv
design/can_interface.sv
design/can_rx_assembler.sv
design/can_bridge_top.sv
test/tb_can_bridge.sv

//--- test/tb_can_bridge_checks.svh
// Check counters shared by the whole testbench
int err_cnt = 0;
int chk_cnt = 0;

// Register word written to the node
task automatic check_word(input string name, input logic [`CAN_ADDR_W-1:0] addr,
                          input can_reg_word_u got, input can_reg_word_u exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("** Error at %0t: %s (addr 0x%02h) got 0x%04h expected 0x%04h",
             $time, name, addr, got, exp);
  end
endtask

// Register address on the node bus
task automatic check_addr(input string name, input logic [`CAN_ADDR_W-1:0] got,
                          input logic [`CAN_ADDR_W-1:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("** Error at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
  end
endtask

// Whole 76-bit message
task automatic check_msg(input string name, input logic [`CAN_MSG_W-1:0] got,
                         input logic [`CAN_MSG_W-1:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("** Error at %0t: %s got 0x%019h expected 0x%019h", $time, name, got, exp);
  end
endtask

// Compare select output
task automatic check_sel(input string name, input logic [`CAN_SEL_W-1:0] got,
                         input logic [`CAN_SEL_W-1:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("** Error at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
  end
endtask

// Event totals
task automatic check_count(input string name, input int got, input int exp);
  chk_cnt++;
  if (got != exp) begin
    err_cnt++;
    $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

task automatic report_problem(input string what);
  err_cnt++;
  $display("Problem at %0t: %s", $time, what);
endtask

//--- test/tb_can_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_bridge_settings.svh"

module tb_can_bridge import can_bridge_pkg::*; ();

  localparam int N_SEND = 40;
  localparam int N_TRIM = 5;
  localparam int N_BRST = 5;
  localparam int N_COMP = 8;  // Each one followed by a send
  localparam int N_RX   = 20;
  localparam int N_REQ  = N_SEND + N_TRIM + N_BRST + 2 * N_COMP;
  localparam int LIMIT_CYCLES = 400 * (N_REQ + N_RX) + 200;

  logic                    clock = 1'b0;
  logic                    rst;
  logic                    req_valid;
  logic [`CAN_OP_W-1:0]    req_op;
  logic [`CAN_MSG_W-1:0]   req_msg;
  logic [2*`CAN_SEL_W-1:0] req_sel;
  logic                    req_ready;
  logic [`CAN_ADDR_W-1:0]  reg_addr;
  can_reg_word_u           reg_wdata;
  logic                    reg_wr;
  logic                    reg_rd;
  logic [`CAN_WORD_W-1:0]  reg_rdata;
  logic                    rx_pending;
  logic                    rx_valid;
  logic [`CAN_MSG_W-1:0]   rx_msg;
  logic                    rx_ready;
  logic [`CAN_SEL_W-1:0]   comp_tx_sel;
  logic [`CAN_SEL_W-1:0]   comp_rx_sel;

  // Node register file and bus log
  logic [`CAN_WORD_W-1:0]  mem [32];
  logic [`CAN_WORD_W-1:0]  rd_buf;
  logic [`CAN_ADDR_W-1:0]  wlog_addr [$];
  can_reg_word_u           wlog_word [$];
  logic [`CAN_MSG_W-1:0]   exp_rx [$];
  int read_cnt = 0;
  int irq_clears = 0;
  int rx_loaded = 0;
  int rx_done = 0;
  bit req_busy = 1'b0;         // Host request in progress
  bit init_done = 1'b0;
  logic [`CAN_SEL_W-1:0]   last_tx_sel = '0;
  logic [`CAN_SEL_W-1:0]   last_rx_sel = '0;

  `include "tb_can_bridge_checks.svh"

  can_bridge_top i_can_bridge_top (
    .clock(clock), .rst(rst), .req_valid(req_valid), .req_op(req_op),
    .req_msg(req_msg), .req_sel(req_sel), .req_ready(req_ready),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wr(reg_wr), .reg_rd(reg_rd),
    .reg_rdata(reg_rdata), .rx_pending(rx_pending), .rx_valid(rx_valid),
    .rx_msg(rx_msg), .rx_ready(rx_ready), .comp_tx_sel(comp_tx_sel),
    .comp_rx_sel(comp_rx_sel)
  );

  always #50 clock = ~clock;

  function automatic logic [`CAN_MSG_W-1:0] rand_msg();
    return {$urandom, $urandom, $urandom};  // Upper bits drop off
  endfunction

  function automatic logic [7:0] byte_of(input logic [`CAN_MSG_W-1:0] m, input int k);
    return m[8*k +: 8];
  endfunction

  // Address order of a transmit
  function automatic logic [`CAN_ADDR_W-1:0] tx_order(input int i);
    logic [`CAN_ADDR_W-1:0] list [7];
    list = '{`ADDR_TX_ID, `ADDR_TX_D12, `ADDR_TX_D34, `ADDR_TX_D56, `ADDR_TX_D78,
             `ADDR_GENERAL, `ADDR_TX_CTRL};
    return list[i];
  endfunction

  // Expected word for transmit step i from the message layout
  function automatic can_reg_word_u tx_word(input int i, input logic [`CAN_MSG_W-1:0] m);
    can_reg_word_u w;
    w = '0;
    case (i)
      0: w.id_word.id = m[74:64];
      1: w.pair = '{byte_of(m, 7), byte_of(m, 5)};
      2: w.pair = '{byte_of(m, 6), byte_of(m, 4)};
      3: w.pair = '{byte_of(m, 0), byte_of(m, 1)};
      4: w.pair = '{byte_of(m, 2), byte_of(m, 3)};
      5: w = `WORD_GENERAL;
      default: w = `WORD_TX_CTRL;
    endcase
    return w;
  endfunction

  // Puts message m into the receive registers in the transmit layout
  task automatic load_rx(input logic [`CAN_MSG_W-1:0] m);
    mem[`ADDR_RX_ID]  = tx_word(0, m);
    mem[`ADDR_RX_D12] = tx_word(1, m);
    mem[`ADDR_RX_D34] = tx_word(2, m);
    mem[`ADDR_RX_D56] = tx_word(3, m);
    mem[`ADDR_RX_D78] = tx_word(4, m);
    exp_rx.push_back({1'b0, m[74:0]});
  endtask

  // Node model answering reads one cycle later
  always @(negedge clock) begin
    reg_rdata = rd_buf;
    if (!rst && reg_rd) begin
      rd_buf = mem[reg_addr];
      read_cnt++;
    end
    if (!rst && reg_wr) begin
      mem[reg_addr] = reg_wdata;
      wlog_addr.push_back(reg_addr);
      wlog_word.push_back(reg_wdata);
      if (reg_addr == `ADDR_IRQ && reg_wdata == `WORD_IRQ_CLEAR) begin
        irq_clears++;
        rx_pending = 1'b0;
      end
    end
    // A new message may arrive while the previous one is still held
    if (init_done && !req_busy && !rx_pending && rx_loaded < N_RX &&
        $urandom_range(0, 9) == 0) begin
      load_rx(rand_msg());
      rx_loaded++;
      rx_pending  = 1'b1;
    end
  end

  // Host side of the receive port with random back-pressure
  always @(negedge clock) begin
    rx_ready = ($urandom_range(0, 2) == 0);
    #1;
    if (!rst && rx_valid && rx_ready) begin
      if (exp_rx.size() == 0) begin
        report_problem("received a message that the node never held");
      end else begin
        check_msg("rx_msg", rx_msg, exp_rx.pop_front());
      end
      rx_done++;
    end
  end

  // Waits for acceptance, then checks the writes or selects it caused
  task automatic run_request(input logic [`CAN_OP_W-1:0] op,
                             input logic [`CAN_MSG_W-1:0] m,
                             input logic [2*`CAN_SEL_W-1:0] sel);
    int start;
    int n;
    req_busy = 1'b1;
    repeat ($urandom_range(1, 6)) @(negedge clock);
    // The IRQ clear of a bus reset would drop a message still waiting in the node
    while (op == `OP_BUS_RESET && rx_pending) @(negedge clock);
    req_valid = 1'b1;
    req_op    = op;
    req_msg   = m;
    req_sel   = sel;
    #1;
    while (!req_ready) begin
      @(negedge clock);
      #1;
    end
    start = wlog_addr.size();
    @(negedge clock);
    req_valid = 1'b0;
    req_msg   = rand_msg();  // Payload is free once accepted
    n = (op == `OP_BUS_RESET) ? 2 : (op == `OP_COMPARE) ? 0 : 7;
    while (wlog_addr.size() < start + n) @(negedge clock);
    for (int i = 0; i < n; i++) begin
      if (op == `OP_BUS_RESET) begin
        check_addr("reg_addr", wlog_addr[start+i], i == 0 ? `ADDR_GENERAL : `ADDR_IRQ);
        check_word("reg_wdata", wlog_addr[start+i], wlog_word[start+i],
                   i == 0 ? `WORD_GENERAL : `WORD_IRQ_CLEAR);
      end else begin
        check_addr("reg_addr", wlog_addr[start+i], tx_order(i));
        check_word("reg_wdata", wlog_addr[start+i], wlog_word[start+i],
                   tx_word(i, op == `OP_TRIM ? `TRIM_PATTERN : m));
      end
    end
    if (op == `OP_COMPARE) begin
      last_tx_sel = sel[`CAN_SEL_W-1:0];
      last_rx_sel = sel[2*`CAN_SEL_W-1:`CAN_SEL_W];
    end
    check_sel("comp_tx_sel", comp_tx_sel, last_tx_sel);
    check_sel("comp_rx_sel", comp_rx_sel, last_rx_sel);
    req_busy = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before, input int chk_before);
    $display("Test %-10s %0d checks, %0d errors", name, chk_cnt - chk_before,
             err_cnt - err_before);
  endtask

  initial begin
    #(LIMIT_CYCLES * 100);
    $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int e0;
    int c0;
    void'($urandom(32'h2663_6daa));
    for (int a = 0; a < 32; a++) begin
      mem[a] = 16'hC300 ^ {a[4:0], a[4:0], a[4:0], 1'b1};
    end
    rst = 1'b1;
    req_valid = 1'b0;
    req_op = `OP_SEND;
    req_msg = '0;
    req_sel = '0;
    reg_rdata = '0;
    rd_buf = '0;
    rx_pending = 1'b0;
    rx_ready = 1'b0;
    repeat (8) @(negedge clock);
    rst = 1'b0;

    e0 = err_cnt;
    c0 = chk_cnt;
    #1;
    while (!req_ready) begin
      @(negedge clock);
      #1;
    end
    check_count("init writes before req_ready", wlog_addr.size(), `INIT_LEN);
    for (int i = 0; i < `INIT_LEN && i < wlog_addr.size(); i++) begin
      check_addr("reg_addr", wlog_addr[i], `INIT_ADDR_TABLE >> (i * `CAN_ADDR_W));
      check_word("reg_wdata", wlog_addr[i], wlog_word[i],
                 `INIT_WORD_TABLE >> (i * `CAN_WORD_W));
    end
    init_done = 1'b1;
    end_test("init", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < N_SEND; i++) run_request(`OP_SEND, rand_msg(), '0);
    end_test("send", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < N_TRIM; i++) run_request(`OP_TRIM, rand_msg(), '0);
    for (int i = 0; i < N_BRST; i++) run_request(`OP_BUS_RESET, rand_msg(), '0);
    end_test("trim_reset", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < N_COMP; i++) begin
      run_request(`OP_COMPARE, rand_msg(), $urandom);
      run_request(`OP_SEND, rand_msg(), $urandom);  // Selects must hold
    end
    end_test("compare", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    while (rx_done < N_RX) @(negedge clock);
    repeat (10) @(negedge clock);
    check_count("received messages", rx_done, N_RX);
    check_count("bus reads", read_cnt, 5 * N_RX);
    check_count("IRQ clear writes", irq_clears, N_BRST + N_RX);
    check_count("bus writes", wlog_addr.size(),
                `INIT_LEN + 7 * (N_SEND + N_TRIM + N_COMP) + 2 * N_BRST + N_RX);
    end_test("receive", e0, c0);

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
